// ==== Makefile ====
TOP = tb_i2c_master

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f compile.f

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f compile.f -Mdir obj_dir
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

// ==== compile.f ====
i2c_pkg.sv
i2c_clk_div.sv
i2c_line_filter.sv
i2c_bit_ctl.sv
i2c_byte_ctl.sv
i2c_master_top.sv
tb_i2c_slave_model.sv
tb_i2c_master.sv

// ==== i2c_bit_ctl.sv ====
`timescale 1ns/1ps
`default_nettype none

module i2c_bit_ctl
    import i2c_pkg::*;
(
    input  wire       i_cmd_trig,
    input  wire       i_nReset,
    input  wire       i_enable,
    input  wire       i_tick,
    input  wire [2:0] i_cmd,
    input  wire       i_din,
    input  wire       i_scl_f,
    input  wire       i_sda_f,
    output logic      o_cmd_ack,
    output logic      o_dout,
    output logic      o_busy,
    output logic      o_arblost,
    output logic      o_scl_oen,
    output logic      o_sda_oen
);

    logic       active;
    logic [2:0] cmd_r;
    logic [1:0] phase;
    logic       din_r;
    logic       wait_scl;
    logic       wait_sda;
    logic       step;
    logic       lost;
    logic [1:0] nxt_lines;
    logic       scl_q;
    logic       sda_q;

    // {scl, sda} enables per command and phase, 1 = released
    function automatic logic [1:0] line_drive(input logic [2:0] cmd,
                                              input logic [1:0] ph,
                                              input logic       din);
        logic [1:0] v;
        v = 2'b11;
        case (cmd)
            BIT_START: begin
                case (ph)
                    2'd0, 2'd1: v = 2'b11;
                    2'd2:       v = 2'b10; // sda falls, scl high
                    default:    v = 2'b00;
                endcase
            end
            BIT_RESTART: begin
                case (ph)
                    2'd0:    v = 2'b01;
                    2'd1:    v = 2'b11;
                    2'd2:    v = 2'b10;
                    default: v = 2'b00;
                endcase
            end
            BIT_STOP: begin
                case (ph)
                    2'd0:    v = 2'b00;
                    2'd1:    v = 2'b10;
                    default: v = 2'b11; // sda rises, scl high
                endcase
            end
            BIT_WRITE: v = {(ph == 2'd1) || (ph == 2'd2), din};
            BIT_READ:  v = {(ph == 2'd1) || (ph == 2'd2), 1'b1};
            default:   v = 2'b11;
        endcase
        return v;
    endfunction

    assign wait_scl = o_scl_oen && !i_scl_f; // slave still holds scl low
    // a start or stop bit ends only once the filtered bus shows it
    assign wait_sda = (phase == 2'd3) &&
                      ((((cmd_r == BIT_START) || (cmd_r == BIT_RESTART)) && i_sda_f) ||
                       ((cmd_r == BIT_STOP) && !i_sda_f));
    assign step      = active && i_tick && !wait_scl && !wait_sda;
    assign lost      = step && (phase == 2'd1) && (cmd_r == BIT_WRITE) && din_r && !i_sda_f;
    assign nxt_lines = line_drive(cmd_r, phase + 2'd1, din_r);

    always_ff @(posedge i_cmd_trig or negedge i_nReset) begin
        if (!i_nReset) begin
            active    <= 1'b0;
            cmd_r     <= BIT_IDLE;
            phase     <= 2'd0;
            din_r     <= 1'b1;
            o_cmd_ack <= 1'b0;
            o_dout    <= 1'b1;
            o_arblost <= 1'b0;
            o_scl_oen <= 1'b1;
            o_sda_oen <= 1'b1;
        end else if (!i_enable) begin
            active    <= 1'b0;
            cmd_r     <= BIT_IDLE;
            phase     <= 2'd0;
            o_cmd_ack <= 1'b0;
            o_arblost <= 1'b0;
            o_scl_oen <= 1'b1;
            o_sda_oen <= 1'b1;
        end else begin
            o_cmd_ack <= 1'b0;
            o_arblost <= 1'b0;
            if (!active) begin
                if (i_cmd != BIT_IDLE) begin
                    active                 <= 1'b1;
                    cmd_r                  <= i_cmd;
                    din_r                  <= i_din;
                    phase                  <= 2'd0;
                    {o_scl_oen, o_sda_oen} <= line_drive(i_cmd, 2'd0, i_din);
                end
            end else if (lost) begin
                active    <= 1'b0; // give the bus up at once
                o_arblost <= 1'b1;
                o_cmd_ack <= 1'b1;
                o_dout    <= i_sda_f;
                o_scl_oen <= 1'b1;
                o_sda_oen <= 1'b1;
            end else if (step) begin
                if (phase == 2'd1) begin
                    o_dout <= i_sda_f; // middle of scl high
                end
                if (phase == 2'd3) begin
                    active    <= 1'b0; // lines keep their last level
                    o_cmd_ack <= 1'b1;
                end else begin
                    phase                  <= phase + 2'd1;
                    {o_scl_oen, o_sda_oen} <= nxt_lines;
                end
            end
        end
    end

    // bus busy from start/stop seen on the filtered lines
    always_ff @(posedge i_cmd_trig or negedge i_nReset) begin
        if (!i_nReset) begin
            scl_q  <= 1'b1;
            sda_q  <= 1'b1;
            o_busy <= 1'b0;
        end else begin
            scl_q <= i_scl_f;
            sda_q <= i_sda_f;
            if (scl_q && i_scl_f && sda_q && !i_sda_f) begin
                o_busy <= 1'b1;
            end else if (scl_q && i_scl_f && !sda_q && i_sda_f) begin
                o_busy <= 1'b0;
            end
        end
    end

    a_cmd_when_idle: assert property (@(posedge i_cmd_trig) disable iff (!i_nReset)
        active |-> (i_cmd == BIT_IDLE))
        else $error("bit command while a bit is in progress");

endmodule

`default_nettype wire

// ==== i2c_byte_ctl.sv ====
`timescale 1ns/1ps
`default_nettype none

module i2c_byte_ctl
    import i2c_pkg::*;
(
    input  wire       i_cmd_trig,
    input  wire       i_nReset,
    input  wire       i_enable,
    input  wire       i_cmd_stb,
    input  wire [3:0] i_cmd,
    input  wire [7:0] i_data,
    input  wire       i_bit_ack,
    input  wire       i_bit_dout,
    input  wire       i_arblost,
    output logic [2:0] o_bit_cmd,
    output logic      o_bit_din,
    output logic      o_cmd_ack,
    output logic      o_i2c_ack,
    output logic [7:0] o_data,
    output logic      o_interrupt
);

    logic       busy_r;
    logic [3:0] cmd_r;
    logic [7:0] shift_r;
    logic [3:0] bit_cnt; // 0..7 data, 8 ack
    logic       accept;
    logic       bit_done;
    logic       is_read;

    assign accept   = i_enable && !busy_r && i_cmd_stb && (i_cmd != CMD_IDLE);
    assign bit_done = i_enable && busy_r && i_bit_ack;
    assign is_read  = (cmd_r == CMD_READ_ACK) || (cmd_r == CMD_READ_NAK);

    // shift register, msb first both ways
    always_ff @(posedge i_cmd_trig) begin
        if (accept) begin
            shift_r <= i_data;
        end else if (bit_done && (bit_cnt < 4'd8)) begin
            shift_r <= {shift_r[6:0], i_bit_dout}; // write side ignores the shifted-in bit
        end
    end

    always_ff @(posedge i_cmd_trig or negedge i_nReset) begin
        if (!i_nReset) begin
            busy_r      <= 1'b0;
            cmd_r       <= CMD_IDLE;
            bit_cnt     <= 4'd0;
            o_bit_cmd   <= BIT_IDLE;
            o_bit_din   <= 1'b1;
            o_cmd_ack   <= 1'b0;
            o_i2c_ack   <= 1'b0;
            o_data      <= 8'hff;
            o_interrupt <= 1'b0;
        end else if (!i_enable) begin
            busy_r      <= 1'b0;
            cmd_r       <= CMD_IDLE;
            bit_cnt     <= 4'd0;
            o_bit_cmd   <= BIT_IDLE;
            o_cmd_ack   <= 1'b0;
            o_data      <= 8'hff;
            o_interrupt <= 1'b0;
        end else begin
            o_bit_cmd   <= BIT_IDLE;
            o_cmd_ack   <= 1'b0;
            o_interrupt <= i_arblost;
            if (accept) begin
                busy_r  <= 1'b1;
                cmd_r   <= i_cmd;
                bit_cnt <= 4'd0;
                case (i_cmd)
                    CMD_START:   o_bit_cmd <= BIT_START;
                    CMD_RESTART: o_bit_cmd <= BIT_RESTART;
                    CMD_STOP:    o_bit_cmd <= BIT_STOP;
                    CMD_WRITE: begin
                        o_bit_cmd <= BIT_WRITE;
                        o_bit_din <= i_data[7];
                    end
                    CMD_READ_ACK, CMD_READ_NAK: begin
                        o_bit_cmd <= BIT_READ;
                        o_bit_din <= 1'b1; // sda released
                    end
                    default: busy_r <= 1'b0; // unknown code dropped
                endcase
            end else if (bit_done) begin
                if (i_arblost || (bit_cnt == 4'd8) ||
                    ((cmd_r != CMD_WRITE) && !is_read)) begin
                    busy_r      <= 1'b0;
                    cmd_r       <= CMD_IDLE;
                    o_cmd_ack   <= 1'b1;
                    o_interrupt <= 1'b1;
                    if (!i_arblost && (cmd_r == CMD_WRITE)) begin
                        o_i2c_ack <= i_bit_dout; // 0 = slave acked
                    end
                    if (!i_arblost && is_read) begin
                        o_data <= shift_r;
                    end
                end else begin
                    bit_cnt <= bit_cnt + 4'd1;
                    if (bit_cnt == 4'd7) begin
                        // ack slot: roles swap
                        o_bit_cmd <= is_read ? BIT_WRITE : BIT_READ;
                        o_bit_din <= is_read ? (cmd_r == CMD_READ_NAK) : 1'b1;
                    end else if (is_read) begin
                        o_bit_cmd <= BIT_READ;
                    end else begin
                        o_bit_cmd <= BIT_WRITE;
                        o_bit_din <= shift_r[6];
                    end
                end
            end
        end
    end

    a_no_stb_busy: assert property (@(posedge i_cmd_trig) disable iff (!i_nReset)
        busy_r |-> !i_cmd_stb)
        else $error("command strobe while a command is active");

endmodule

`default_nettype wire

// ==== i2c_clk_div.sv ====
`timescale 1ns/1ps
`default_nettype none

module i2c_clk_div
    import i2c_pkg::*;
#(
    parameter int PRESCALE_W = PRESCALE_W_DEF
) (
    input  wire                  i_cmd_trig,
    input  wire                  i_nReset,
    input  wire                  i_enable,
    input  wire [PRESCALE_W-1:0] i_prescale,
    output logic                 o_tick
);

    logic [PRESCALE_W-1:0] cnt;

    // one tick every i_prescale+1 cycles
    always_ff @(posedge i_cmd_trig or negedge i_nReset) begin
        if (!i_nReset) begin
            cnt    <= '0;
            o_tick <= 1'b0;
        end else if (!i_enable) begin
            cnt    <= i_prescale; // parked at reload
            o_tick <= 1'b0;
        end else if (cnt == '0) begin
            cnt    <= i_prescale;
            o_tick <= 1'b1;
        end else begin
            cnt    <= cnt - 1'b1;
            o_tick <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== i2c_line_filter.sv ====
`timescale 1ns/1ps
`default_nettype none

module i2c_line_filter
    import i2c_pkg::*;
#(
    parameter int DFSR_W = DFSR_W_DEF
) (
    input  wire              i_cmd_trig,
    input  wire              i_nReset,
    input  wire [DFSR_W-1:0] i_dfsr,
    input  wire              i_line,
    output logic             o_line
);

    logic [1:0]        sync_q;
    logic [DFSR_W-1:0] smp_cnt;
    logic              smp_en;
    logic [2:0]        hist;
    logic              vote;

    // pad input is asynchronous to us
    always_ff @(posedge i_cmd_trig or negedge i_nReset) begin
        if (!i_nReset) begin
            sync_q <= 2'b11;
        end else begin
            sync_q <= {sync_q[0], i_line};
        end
    end

    // sample strobe every i_dfsr+1 cycles
    always_ff @(posedge i_cmd_trig or negedge i_nReset) begin
        if (!i_nReset) begin
            smp_cnt <= '0;
        end else if (smp_cnt == '0) begin
            smp_cnt <= i_dfsr;
        end else begin
            smp_cnt <= smp_cnt - 1'b1;
        end
    end

    assign smp_en = (smp_cnt == '0);

    always_ff @(posedge i_cmd_trig or negedge i_nReset) begin
        if (!i_nReset) begin
            hist <= 3'b111; // idle bus reads high
        end else if (smp_en) begin
            hist <= {hist[1:0], sync_q[1]};
        end
    end

    // two out of three
    assign vote = (hist[0] & hist[1]) | (hist[1] & hist[2]) | (hist[0] & hist[2]);

    always_ff @(posedge i_cmd_trig or negedge i_nReset) begin
        if (!i_nReset) begin
            o_line <= 1'b1;
        end else begin
            o_line <= vote;
        end
    end

endmodule

`default_nettype wire

// ==== i2c_master_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module i2c_master_top
    import i2c_pkg::*;
#(
    parameter int PRESCALE_W = PRESCALE_W_DEF,
    parameter int DFSR_W     = DFSR_W_DEF
) (
    input  wire                  i_cmd_trig,
    input  wire                  i_nReset,
    input  wire                  i_enable,
    input  wire [PRESCALE_W-1:0] i_prescale,
    input  wire [DFSR_W-1:0]     i_dfsr,
    input  wire                  i_cmd_stb,
    input  wire [3:0]            i_cmd,
    input  wire [7:0]            i_data,
    input  wire                  i_scl,
    input  wire                  i_sda,
    output logic                 o_cmd_ack,
    output logic                 o_i2c_ack,
    output logic                 o_i2c_al,
    output logic                 o_i2c_busy,
    output logic [7:0]           o_data,
    output logic                 o_scl,
    output logic                 o_scl_oen,
    output logic                 o_sda,
    output logic                 o_sda_oen,
    output logic                 o_interrupt
);

    logic       phase_tick;
    logic       scl_f;
    logic       sda_f;
    logic [2:0] bit_cmd;
    logic       bit_din;
    logic       bit_ack;
    logic       bit_dout;

    assign o_scl = 1'b0; // open drain, only the enables toggle
    assign o_sda = 1'b0;

    i2c_clk_div #(.PRESCALE_W(PRESCALE_W)) u_clk_div (
        .i_cmd_trig (i_cmd_trig),
        .i_nReset   (i_nReset),
        .i_enable   (i_enable),
        .i_prescale (i_prescale),
        .o_tick     (phase_tick)
    );

    i2c_line_filter #(.DFSR_W(DFSR_W)) u_scl_filt (
        .i_cmd_trig (i_cmd_trig),
        .i_nReset   (i_nReset),
        .i_dfsr     (i_dfsr),
        .i_line     (i_scl),
        .o_line     (scl_f)
    );

    i2c_line_filter #(.DFSR_W(DFSR_W)) u_sda_filt (
        .i_cmd_trig (i_cmd_trig),
        .i_nReset   (i_nReset),
        .i_dfsr     (i_dfsr),
        .i_line     (i_sda),
        .o_line     (sda_f)
    );

    i2c_bit_ctl u_bit_ctl (
        .i_cmd_trig (i_cmd_trig),
        .i_nReset   (i_nReset),
        .i_enable   (i_enable),
        .i_tick     (phase_tick),
        .i_cmd      (bit_cmd),
        .i_din      (bit_din),
        .i_scl_f    (scl_f),
        .i_sda_f    (sda_f),
        .o_cmd_ack  (bit_ack),
        .o_dout     (bit_dout),
        .o_busy     (o_i2c_busy),
        .o_arblost  (o_i2c_al),
        .o_scl_oen  (o_scl_oen),
        .o_sda_oen  (o_sda_oen)
    );

    i2c_byte_ctl u_byte_ctl (
        .i_cmd_trig  (i_cmd_trig),
        .i_nReset    (i_nReset),
        .i_enable    (i_enable),
        .i_cmd_stb   (i_cmd_stb),
        .i_cmd       (i_cmd),
        .i_data      (i_data),
        .i_bit_ack   (bit_ack),
        .i_bit_dout  (bit_dout),
        .i_arblost   (o_i2c_al),
        .o_bit_cmd   (bit_cmd),
        .o_bit_din   (bit_din),
        .o_cmd_ack   (o_cmd_ack),
        .o_i2c_ack   (o_i2c_ack),
        .o_data      (o_data),
        .o_interrupt (o_interrupt)
    );

endmodule

`default_nettype wire

// ==== i2c_pkg.sv ====
`default_nettype none

package i2c_pkg;

    // byte level commands seen at the top level port
    localparam logic [3:0] CMD_IDLE     = 4'h0;
    localparam logic [3:0] CMD_START    = 4'h1;
    localparam logic [3:0] CMD_WRITE    = 4'h2;
    localparam logic [3:0] CMD_READ_ACK = 4'h3; // read byte, master acks
    localparam logic [3:0] CMD_READ_NAK = 4'h4; // read byte, last one
    localparam logic [3:0] CMD_RESTART  = 4'h5;
    localparam logic [3:0] CMD_STOP     = 4'h6;

    // single bit operations toward the bit engine
    localparam logic [2:0] BIT_IDLE     = 3'd0;
    localparam logic [2:0] BIT_START    = 3'd1;
    localparam logic [2:0] BIT_WRITE    = 3'd2;
    localparam logic [2:0] BIT_READ     = 3'd3;
    localparam logic [2:0] BIT_RESTART  = 3'd4;
    localparam logic [2:0] BIT_STOP     = 3'd5;

    localparam int PRESCALE_W_DEF = 16; // scl prescale counter
    localparam int DFSR_W_DEF     = 6;  // filter sampling counter

endpackage

`default_nettype wire

// ==== tb_i2c_master.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_i2c_master
    import i2c_pkg::*;
();

    logic        cmd_trig;
    logic        rst_n;
    logic        enable;
    logic [15:0] prescale;
    logic [5:0]  dfsr;
    logic        cmd_stb;
    logic [3:0]  cmd;
    logic [7:0]  data;
    logic        force_low;

    logic        cmd_ack;
    logic        i2c_ack;
    logic        i2c_al;
    logic        i2c_busy;
    logic [7:0]  rd_data;
    logic        m_scl;
    logic        m_scl_oen;
    logic        m_sda;
    logic        m_sda_oen;
    logic        interrupt;
    logic        s_sda_oen;
    logic [7:0]  last_wr;
    logic [7:0]  wr_cnt;
    wire         scl_bus;
    wire         sda_bus;

    // stimulus table, one entry per command
    string       t_name[$];
    logic [3:0]  t_cmd[$];
    logic [7:0]  t_data[$];
    logic        t_ack[$];
    logic [7:0]  t_exp[$];
    logic        t_chk[$];
    logic        t_arb[$];

    // wired and with pull-ups
    assign scl_bus = m_scl_oen ? 1'b1 : m_scl;
    assign sda_bus = (m_sda_oen ? 1'b1 : m_sda) & s_sda_oen;

    i2c_master_top #(.PRESCALE_W(16), .DFSR_W(6)) UUT (
        .i_cmd_trig  (cmd_trig),
        .i_nReset    (rst_n),
        .i_enable    (enable),
        .i_prescale  (prescale),
        .i_dfsr      (dfsr),
        .i_cmd_stb   (cmd_stb),
        .i_cmd       (cmd),
        .i_data      (data),
        .i_scl       (scl_bus),
        .i_sda       (sda_bus),
        .o_cmd_ack   (cmd_ack),
        .o_i2c_ack   (i2c_ack),
        .o_i2c_al    (i2c_al),
        .o_i2c_busy  (i2c_busy),
        .o_data      (rd_data),
        .o_scl       (m_scl),
        .o_scl_oen   (m_scl_oen),
        .o_sda       (m_sda),
        .o_sda_oen   (m_sda_oen),
        .o_interrupt (interrupt)
    );

    tb_i2c_slave_model #(.ADDR(7'h2a)) u_slave (
        .i_cmd_trig  (cmd_trig),
        .i_nReset    (rst_n),
        .i_scl       (scl_bus),
        .i_sda       (sda_bus),
        .i_force_low (force_low),
        .o_sda_oen   (s_sda_oen),
        .o_last_wr   (last_wr),
        .o_wr_cnt    (wr_cnt)
    );

    always #4 cmd_trig = ~cmd_trig;

    task automatic check_equal(input string name, input logic [7:0] exp, input logic [7:0] act);
        if (act !== exp) begin
            $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
            $display("Checks failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic add_row(input string name, input logic [3:0] c, input logic [7:0] d,
                           input logic ack, input logic [7:0] exp, input logic chk,
                           input logic arb);
        t_name.push_back(name);
        t_cmd.push_back(c);
        t_data.push_back(d);
        t_ack.push_back(ack);
        t_exp.push_back(exp);
        t_chk.push_back(chk);
        t_arb.push_back(arb);
    endtask

    task automatic wait_cmd_ack(output logic al_seen);
        int n;
        n = 0;
        al_seen = 1'b0;
        @(posedge cmd_trig);
        while (!cmd_ack && (n < 2000)) begin
            if (i2c_al) begin
                al_seen = 1'b1; // al comes one cycle ahead of the ack
            end
            @(posedge cmd_trig);
            n++;
        end
        if (!cmd_ack) begin
            $display("Checks failed");
            $fatal(1, "no command acknowledge");
        end
    endtask

    task automatic wait_bus_free();
        int n;
        n = 0;
        @(posedge cmd_trig);
        while (i2c_busy && (n < 500)) begin
            @(posedge cmd_trig);
            n++;
        end
        if (i2c_busy) begin
            $display("Checks failed");
            $fatal(1, "bus still busy after the slave released sda");
        end
    endtask

    task automatic wait_disabled();
        int n;
        n = 0;
        @(posedge cmd_trig);
        while ((rd_data !== 8'hff) && (n < 20)) begin
            @(posedge cmd_trig);
            n++;
        end
        if (rd_data !== 8'hff) begin
            $display("Checks failed");
            $fatal(1, "read data did not return to ff after disable");
        end
    endtask

    initial begin
        logic [31:0] rnd;
        logic [7:0]  byte0;
        logic [7:0]  byte1;
        logic        al_seen;
        int          n_wr;
        cmd_trig  = 1'b0;
        rst_n     = 1'b0;
        enable    = 1'b1;
        prescale  = 16'd4;
        dfsr      = 6'd1;
        cmd_stb   = 1'b0;
        cmd       = CMD_IDLE;
        data      = 8'h00;
        force_low = 1'b0;
        n_wr      = 0;
        void'($urandom(32'hcadd5c94));
        rnd   = $urandom();
        byte0 = rnd[7:0];
        rnd   = $urandom();
        byte1 = rnd[7:0];

        add_row("start_wr",   CMD_START,    8'h00, 1'b0, 8'h00, 1'b0, 1'b0);
        add_row("addr_wr",    CMD_WRITE,    8'h54, 1'b0, 8'h00, 1'b0, 1'b0);
        add_row("data0",      CMD_WRITE,    byte0, 1'b0, byte0, 1'b1, 1'b0);
        add_row("data1",      CMD_WRITE,    byte1, 1'b0, byte1, 1'b1, 1'b0);
        add_row("restart",    CMD_RESTART,  8'h00, 1'b0, 8'h00, 1'b0, 1'b0);
        add_row("addr_wrong", CMD_WRITE,    8'h62, 1'b1, 8'h00, 1'b0, 1'b0);
        add_row("stop_wr",    CMD_STOP,     8'h00, 1'b0, 8'h00, 1'b0, 1'b0);
        add_row("start_rd",   CMD_START,    8'h00, 1'b0, 8'h00, 1'b0, 1'b0);
        add_row("addr_rd",    CMD_WRITE,    8'h55, 1'b0, 8'h00, 1'b0, 1'b0);
        add_row("read_ack",   CMD_READ_ACK, 8'h00, 1'b0, 8'h5c, 1'b1, 1'b0);
        add_row("read_nak",   CMD_READ_NAK, 8'h00, 1'b0, 8'ha3, 1'b1, 1'b0);
        add_row("stop_rd",    CMD_STOP,     8'h00, 1'b0, 8'h00, 1'b0, 1'b0);
        add_row("start_al",   CMD_START,    8'h00, 1'b0, 8'h00, 1'b0, 1'b0);
        add_row("write_al",   CMD_WRITE,    8'hff, 1'b0, 8'h00, 1'b0, 1'b1);
        add_row("start_hold", CMD_START,    8'h00, 1'b0, 8'h00, 1'b0, 1'b0);

        repeat (2) @(posedge cmd_trig);
        rst_n <= 1'b1;

        for (int i = 0; i < t_cmd.size(); i++) begin
            @(posedge cmd_trig);
            cmd_stb   <= 1'b1;
            cmd       <= t_cmd[i];
            data      <= t_data[i];
            force_low <= t_arb[i];
            @(posedge cmd_trig);
            cmd_stb <= 1'b0;
            wait_cmd_ack(al_seen);
            check_equal({t_name[i], " interrupt"}, 8'd1, 8'(interrupt));
            check_equal({t_name[i], " arb lost"}, 8'(t_arb[i]), 8'(al_seen));
            if ((t_cmd[i] == CMD_WRITE) && !t_arb[i]) begin
                check_equal({t_name[i], " ack"}, 8'(t_ack[i]), 8'(i2c_ack));
            end
            if (t_chk[i] && (t_cmd[i] == CMD_WRITE)) begin
                n_wr++;
                check_equal({t_name[i], " slave byte"}, t_exp[i], last_wr);
                check_equal({t_name[i], " slave count"}, 8'(n_wr), wr_cnt);
            end else if (t_chk[i]) begin
                check_equal({t_name[i], " read data"}, t_exp[i], rd_data);
            end
            if (t_cmd[i] == CMD_START) begin
                check_equal({t_name[i], " busy"}, 8'd1, 8'(i2c_busy));
            end
            if (t_cmd[i] == CMD_STOP) begin
                check_equal({t_name[i], " busy"}, 8'd0, 8'(i2c_busy));
            end
            if (t_arb[i]) begin
                @(posedge cmd_trig);
                force_low <= 1'b0; // sda rises with scl high
                wait_bus_free();
            end
        end

        // start leaves both lines pulled low
        @(posedge cmd_trig);
        check_equal("held scl_oen", 8'd0, 8'(m_scl_oen));
        check_equal("held sda_oen", 8'd0, 8'(m_sda_oen));
        enable <= 1'b0;
        wait_disabled();
        check_equal("disable scl_oen", 8'd1, 8'(m_scl_oen));
        check_equal("disable sda_oen", 8'd1, 8'(m_sda_oen));
        check_equal("disable cmd_ack", 8'd0, 8'(cmd_ack));
        check_equal("disable interrupt", 8'd0, 8'(interrupt));
        check_equal("disable arb lost", 8'd0, 8'(i2c_al));

        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb_i2c_slave_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_i2c_slave_model #(
    parameter logic [6:0] ADDR = 7'h2a
) (
    input  wire        i_cmd_trig,
    input  wire        i_nReset,
    input  wire        i_scl,
    input  wire        i_sda,
    input  wire        i_force_low,
    output logic       o_sda_oen,
    output logic [7:0] o_last_wr,
    output logic [7:0] o_wr_cnt
);

    localparam logic [1:0] S_IDLE  = 2'd0;
    localparam logic [1:0] S_ADDR  = 2'd1;
    localparam logic [1:0] S_WRITE = 2'd2;
    localparam logic [1:0] S_READ  = 2'd3;

    logic [7:0] rd_table [0:1];
    logic [1:0] state;
    logic [3:0] cnt; // scl rising edges in the frame
    logic [7:0] shift;
    logic [7:0] tx;
    logic       rd_idx;
    logic       mack;
    logic       drive;
    logic       scl_q;
    logic       sda_q;

    initial begin
        rd_table[0] = 8'h5c;
        rd_table[1] = 8'ha3;
    end

    assign o_sda_oen = drive && !i_force_low; // forced mode pins sda low

    // bus is oversampled on the tb clock
    always @(posedge i_cmd_trig or negedge i_nReset) begin
        if (!i_nReset) begin
            state     <= S_IDLE;
            cnt       <= 4'd0;
            shift     <= 8'h00;
            tx        <= 8'hff;
            rd_idx    <= 1'b0;
            mack      <= 1'b1;
            drive     <= 1'b1;
            scl_q     <= 1'b1;
            sda_q     <= 1'b1;
            o_last_wr <= 8'h00;
            o_wr_cnt  <= 8'h00;
        end else begin
            scl_q <= i_scl;
            sda_q <= i_sda;
            if (scl_q && i_scl && sda_q && !i_sda) begin
                state  <= S_ADDR; // start or repeated start
                cnt    <= 4'd0;
                rd_idx <= 1'b0;
                drive  <= 1'b1;
            end else if (scl_q && i_scl && !sda_q && i_sda) begin
                state <= S_IDLE; // stop
                cnt   <= 4'd0;
                drive <= 1'b1;
            end else if ((state != S_IDLE) && !scl_q && i_scl) begin
                cnt <= cnt + 4'd1;
                if (cnt < 4'd8) begin
                    shift <= {shift[6:0], i_sda};
                end else begin
                    mack <= i_sda; // master ack after a read byte
                end
            end else if ((state != S_IDLE) && scl_q && !i_scl) begin
                if (cnt == 4'd8) begin
                    case (state)
                        S_ADDR:  drive <= (shift[7:1] != ADDR);
                        S_WRITE: begin
                            drive     <= 1'b0;
                            o_last_wr <= shift;
                            o_wr_cnt  <= o_wr_cnt + 8'd1;
                        end
                        default: drive <= 1'b1;
                    endcase
                end else if (cnt == 4'd9) begin
                    cnt <= 4'd0;
                    if ((state == S_ADDR) && (shift[7:1] != ADDR)) begin
                        state <= S_IDLE;
                        drive <= 1'b1;
                    end else if ((state == S_ADDR) && shift[0]) begin
                        state <= S_READ;
                        tx    <= rd_table[rd_idx];
                        drive <= rd_table[rd_idx][7];
                    end else if ((state == S_READ) && !mack) begin
                        rd_idx <= ~rd_idx; // next table entry
                        tx     <= rd_table[~rd_idx];
                        drive  <= rd_table[~rd_idx][7];
                    end else if (state == S_READ) begin
                        state <= S_IDLE; // nak ends the read
                        drive <= 1'b1;
                    end else begin
                        state <= S_WRITE;
                        drive <= 1'b1;
                    end
                end else if ((state == S_READ) && (cnt != 4'd0)) begin
                    drive <= tx[3'd7 - cnt[2:0]];
                end else begin
                    drive <= 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire
